//--- dv/uart_tb_vectors.svh
localparam logic [1:0] MODE_LOOP       = 2'd0;	// tx line looped back to rx
localparam logic [1:0] MODE_BAD_PARITY = 2'd1;	// injected frame with the parity bit inverted
localparam logic [1:0] MODE_BAD_STOP   = 2'd2;	// injected frame with a low stop bit

localparam int NUM_ROWS = 10;

// each row is {data word, mode, second start during busy, expect valid (else error)}
function automatic logic [11:0] vector_row(input int idx);
	case (idx)
		0:       vector_row = {8'h55, MODE_LOOP,       1'b0, 1'b1};
		1:       vector_row = {8'ha3, MODE_LOOP,       1'b1, 1'b1};
		2:       vector_row = {8'h00, MODE_LOOP,       1'b0, 1'b1};
		3:       vector_row = {8'hff, MODE_LOOP,       1'b0, 1'b1};
		4:       vector_row = {8'h3c, MODE_BAD_PARITY, 1'b0, 1'b0};
		5:       vector_row = {8'h81, MODE_BAD_STOP,   1'b0, 1'b0};
		6:       vector_row = {8'h5a, MODE_LOOP,       1'b0, 1'b1};	// good frame after a stop error
		7:       vector_row = {8'h0f, MODE_LOOP,       1'b1, 1'b1};
		8:       vector_row = {8'hc6, MODE_BAD_PARITY, 1'b0, 1'b0};
		default: vector_row = {8'h7e, MODE_LOOP,       1'b0, 1'b1};
	endcase
endfunction

//--- dv/uart_tb.sv
module uart_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import uart_frame_pkg::*;

	localparam int DATA_WIDTH   = 8;
	localparam int CPB          = 8;	// clocks per bit
	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 4;
	localparam int FRAME_BITS   = DATA_WIDTH + 3;	// start, data, parity, stop
	localparam int NUM_RANDOM   = 8;

	`include "uart_tb_vectors.svh"

	localparam int WATCHDOG_NS =
		(NUM_ROWS + NUM_RANDOM + 2) * FRAME_BITS * CPB * CLK_PERIOD * 2;
	localparam int OUTCOME_LIMIT = 2 * FRAME_BITS * CPB;

	logic                  clk;
	logic                  reset;
	logic                  tx_start;
	logic [DATA_WIDTH-1:0] tx_data;
	logic                  tx_busy;
	logic                  tx_line;
	logic                  rx_line;
	logic [DATA_WIDTH-1:0] rx_data;
	logic                  rx_valid;
	logic                  rx_error;
	logic                  loop_sel;
	logic                  inj_line;
	int                    errors;
	int                    frames;
	int                    valid_seen;
	int                    error_seen;
	logic [DATA_WIDTH-1:0] last_rx_word;
	logic [DATA_WIDTH-1:0] last_good;
	logic                  have_good;
	integer                seed;
	logic [11:0]           row;

	assign rx_line = loop_sel ? tx_line : inj_line;	// loopback or bit-banged frame

	uart_top #(
		.DATA_WIDTH     (DATA_WIDTH),
		.CLOCKS_PER_BIT (CPB),
		.PARITY_MODE    (PARITY_EVEN)
	) uut (
		.clk        (clk),
		.reset      (reset),
		.i_tx_start (tx_start),
		.i_tx_data  (tx_data),
		.o_tx_busy  (tx_busy),
		.o_serial   (tx_line),
		.i_serial   (rx_line),
		.o_rx_data  (rx_data),
		.o_rx_valid (rx_valid),
		.o_rx_error (rx_error)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// counts receive pulses and keeps the word of the last valid one
	always @(negedge clk) begin
		if (rx_valid === 1'b1) begin
			valid_seen   = valid_seen + 1;
			last_rx_word = rx_data;
		end
		if (rx_error === 1'b1) begin
			error_seen = error_seen + 1;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	function automatic logic expected_line_bit(input logic [DATA_WIDTH-1:0] w, input int idx);
		if (idx == 0) expected_line_bit = 1'b0;	// start bit
		else if (idx <= DATA_WIDTH) expected_line_bit = w[idx-1];	// lsb first
		else if (idx == DATA_WIDTH + 1) expected_line_bit = ^w;	// even parity
		else expected_line_bit = 1'b1;	// stop bit
	endfunction

	task automatic check_reset_state(input int n);
		repeat (n) begin
			if (tx_line !== 1'b1 || tx_busy !== 1'b0 || rx_valid !== 1'b0 || rx_error !== 1'b0) begin
				$display("ERR %0t: after reset line=%b busy=%b valid=%b error=%b",
					$time, tx_line, tx_busy, rx_valid, rx_error);
				errors++;
			end
			@(negedge clk);
		end
	endtask

	// starts a frame and checks its shape bit by bit at mid-bit
	task automatic send_and_check(input logic [DATA_WIDTH-1:0] word, input logic dup_start);
		int cycle;
		tx_data  = word;
		tx_start = 1'b1;
		@(negedge clk);
		tx_start = 1'b0;
		tx_data  = ~word;	// word was captured at acceptance
		cycle    = 0;
		while (tx_busy === 1'b1 && cycle < 2 * FRAME_BITS * CPB) begin
			if (cycle % CPB == CPB / 2 && cycle / CPB < FRAME_BITS) begin
				if (tx_line !== expected_line_bit(word, cycle / CPB)) begin
					$display("ERR %0t: word %h bit %0d line=%b expected %b", $time, word,
						cycle / CPB, tx_line, expected_line_bit(word, cycle / CPB));
					errors++;
				end
			end
			tx_start = dup_start && cycle == 3 * CPB;	// second strobe while busy
			cycle++;
			@(negedge clk);
		end
		tx_start = 1'b0;
		if (cycle != FRAME_BITS * CPB) begin
			$display("ERR %0t: busy lasted %0d cycles, expected %0d", $time, cycle,
				FRAME_BITS * CPB);
			errors++;
		end
	endtask

	task automatic inject_frame(input logic [DATA_WIDTH-1:0] word, input logic [1:0] mode);
		logic [FRAME_BITS-1:0] bits;
		bits[0] = 1'b0;
		bits[DATA_WIDTH:1] = word;
		bits[DATA_WIDTH+1] = ^word ^ (mode == MODE_BAD_PARITY);
		bits[DATA_WIDTH+2] = mode != MODE_BAD_STOP;
		for (int i = 0; i < FRAME_BITS; i++) begin
			inj_line = bits[i];
			repeat (CPB) @(negedge clk);
		end
		inj_line = 1'b1;
	endtask

	task automatic wait_for_outcome(input int v0, input int e0);
		int waited;
		waited = 0;
		while (valid_seen == v0 && error_seen == e0 && waited < OUTCOME_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (valid_seen == v0 && error_seen == e0) begin
			$display("no receive pulse seen within %0d cycles at %0t", OUTCOME_LIMIT, $time);
			errors++;
		end
	endtask

	// busy must stay low in the gap between frames
	task automatic settle_idle(input int n);
		repeat (n) begin
			if (tx_busy !== 1'b0) begin
				$display("ERR %0t: transmitter busy while idle", $time);
				errors++;
			end
			@(negedge clk);
		end
	endtask

	task automatic run_frame(input logic [DATA_WIDTH-1:0] word, input logic [1:0] mode,
			input logic dup_start, input logic expect_valid);
		int v0;
		int e0;
		v0       = valid_seen;
		e0       = error_seen;
		loop_sel = mode == MODE_LOOP;
		if (mode == MODE_LOOP) send_and_check(word, dup_start);
		else inject_frame(word, mode);
		wait_for_outcome(v0, e0);
		settle_idle(2 * CPB);
		if (expect_valid) begin
			if (valid_seen - v0 != 1 || error_seen != e0 || last_rx_word !== word) begin
				$display("ERR %0t: word %h got %0d valid, %0d error, data %h", $time, word,
					valid_seen - v0, error_seen - e0, last_rx_word);
				errors++;
			end
			last_good = word;
			have_good = 1'b1;
		end else if (error_seen - e0 != 1 || valid_seen != v0) begin
			$display("ERR %0t: word %h got %0d error, %0d valid, expected one error", $time,
				word, error_seen - e0, valid_seen - v0);
			errors++;
		end
		if (have_good && rx_data !== last_good) begin
			$display("ERR %0t: rx data %h, expected held %h", $time, rx_data, last_good);
			errors++;
		end
		frames++;
	endtask

	initial begin
		seed       = 32'hdf93_2e93;
		errors     = 0;
		frames     = 0;
		valid_seen = 0;
		error_seen = 0;
		have_good  = 1'b0;
		reset      = 1'b1;
		tx_start   = 1'b0;
		tx_data    = '0;
		loop_sel   = 1'b1;
		inj_line   = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_reset_state(4);
		for (int i = 0; i < NUM_ROWS; i++) begin
			row = vector_row(i);
			run_frame(row[11:4], row[3:2], row[1], row[0]);
		end
		for (int i = 0; i < NUM_RANDOM; i++) begin
			run_frame(DATA_WIDTH'($random(seed)), MODE_LOOP, 1'b0, 1'b1);
		end
		$display("summary: %0d errors, %0d frames, %0d valid pulses, %0d error pulses",
			errors, frames, valid_seen, error_seen);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+dv
logic/uart_frame_pkg.sv
logic/uart_state_pkg.sv
logic/bit_timer.sv
logic/tx_shifter.sv
logic/rx_deserializer.sv
logic/uart_sequencer.sv
logic/uart_top.sv
dv/uart_tb.sv

//--- logic/bit_timer.sv
module bit_timer #(
	parameter int CLOCKS_PER_BIT = uart_frame_pkg::DEFAULT_CLOCKS_PER_BIT,
	parameter uart_frame_pkg::bit_phase_e PHASE = uart_frame_pkg::PHASE_BOUNDARY
) (
	input  logic clk,
	input  logic reset,
	input  logic i_restart,
	input  logic i_run,
	output logic o_tick
);
	import uart_frame_pkg::*;

	localparam int CNT_W = (CLOCKS_PER_BIT > 1) ? $clog2(CLOCKS_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(CLOCKS_PER_BIT - 1);
	// middle mode starts part way through so the first tick lands at mid-bit
	localparam logic [CNT_W-1:0] RELOAD =
		(PHASE == PHASE_MIDDLE) ? CNT_W'(CLOCKS_PER_BIT - CLOCKS_PER_BIT / 2) : '0;

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (i_restart) begin
			count <= RELOAD;
		end else if (i_run) begin
			count <= (count == LAST) ? '0 : count + 1'b1;	// wrap each period
		end
	end

	assign o_tick = i_run && (count == LAST);

endmodule

//--- logic/rx_deserializer.sv
module rx_deserializer #(
	parameter int DATA_WIDTH = uart_frame_pkg::DEFAULT_DATA_WIDTH,
	parameter uart_frame_pkg::parity_mode_e PARITY_MODE = uart_frame_pkg::PARITY_EVEN
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      i_serial,
	input  logic                      i_sample,
	input  uart_state_pkg::rx_state_e i_state,
	output logic                      o_start_edge,
	output logic                      o_line,
	output logic [DATA_WIDTH-1:0]     o_data,
	output logic                      o_valid,
	output logic                      o_error
);
	import uart_frame_pkg::*;
	import uart_state_pkg::*;

	logic                  sync_1;
	logic                  sync_2;
	logic                  line_prev;
	logic [DATA_WIDTH-1:0] shreg;
	logic                  par_acc;
	logic                  par_err;

	// two-flop synchronizer plus one stage for edge detection
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_1    <= 1'b1;
			sync_2    <= 1'b1;
			line_prev <= 1'b1;
		end else begin
			sync_1    <= i_serial;
			sync_2    <= sync_1;
			line_prev <= sync_2;
		end
	end

	assign o_line       = sync_2;
	assign o_start_edge = line_prev && !sync_2;	// high to low

	always_ff @(posedge clk) begin
		if (i_sample && i_state == RX_DATA) begin
			shreg <= {sync_2, shreg[DATA_WIDTH-1:1]};	// lsb arrives first
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			par_acc <= 1'b0;
			par_err <= 1'b0;
		end else if (i_sample) begin
			case (i_state)
				RX_START: begin
					par_acc <= 1'b0;
					par_err <= 1'b0;
				end
				RX_DATA:   par_acc <= par_acc ^ sync_2;
				RX_PARITY: par_err <= par_acc ^ sync_2 ^ (PARITY_MODE == PARITY_ODD);
				default:   par_acc <= par_acc;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_valid <= 1'b0;
			o_error <= 1'b0;
		end else begin
			o_valid <= i_sample && i_state == RX_STOP && !par_err && sync_2;
			o_error <= i_sample && i_state == RX_STOP && (par_err || !sync_2);
		end
	end

	// holds the last good word until the next one arrives
	always_ff @(posedge clk) begin
		if (i_sample && i_state == RX_STOP && !par_err && sync_2) begin
			o_data <= shreg;
		end
	end

endmodule

//--- logic/tx_shifter.sv
module tx_shifter #(
	parameter int DATA_WIDTH = uart_frame_pkg::DEFAULT_DATA_WIDTH,
	parameter uart_frame_pkg::parity_mode_e PARITY_MODE = uart_frame_pkg::PARITY_EVEN
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      i_load,
	input  logic                      i_shift,
	input  logic [DATA_WIDTH-1:0]     i_data,
	input  uart_state_pkg::tx_state_e i_line_sel,
	output logic                      o_serial
);
	import uart_frame_pkg::*;
	import uart_state_pkg::*;

	logic [DATA_WIDTH-1:0] shreg;
	logic [DATA_WIDTH-1:0] shreg_nxt;
	logic                  parity_bit;
	logic                  line_nxt;

	always_comb begin
		shreg_nxt = shreg;
		if (i_load) begin
			shreg_nxt = i_data;
		end else if (i_shift) begin
			shreg_nxt = shreg >> 1;	// next data bit moves to bit 0
		end
	end

	// i_line_sel is the state of the coming cycle, so the flop lines up with it
	always_comb begin
		case (i_line_sel)
			TX_START:  line_nxt = 1'b0;
			TX_DATA:   line_nxt = shreg_nxt[0];
			TX_PARITY: line_nxt = parity_bit;
			default:   line_nxt = 1'b1;	// idle and stop
		endcase
	end

	always_ff @(posedge clk) begin
		shreg <= shreg_nxt;
		if (i_load) begin
			parity_bit <= (^i_data) ^ (PARITY_MODE == PARITY_ODD);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_serial <= 1'b1;
		end else begin
			o_serial <= line_nxt;	// registered so the line cannot glitch
		end
	end

endmodule

//--- logic/uart_frame_pkg.sv
package uart_frame_pkg;

	// parity option of the frame
	typedef enum logic [1:0] {
		PARITY_NONE,
		PARITY_EVEN,
		PARITY_ODD
	} parity_mode_e;

	// where a bit timer places its tick
	typedef enum logic {
		PHASE_BOUNDARY,	// last cycle of each bit period
		PHASE_MIDDLE	// first tick half a period after restart
	} bit_phase_e;

	localparam int DEFAULT_DATA_WIDTH     = 8;	// data bits per frame
	localparam int DEFAULT_CLOCKS_PER_BIT = 8;	// clocks per serial bit

endpackage

//--- logic/uart_sequencer.sv
module uart_sequencer #(
	parameter int DATA_WIDTH = uart_frame_pkg::DEFAULT_DATA_WIDTH,
	parameter uart_frame_pkg::parity_mode_e PARITY_MODE = uart_frame_pkg::PARITY_EVEN
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      i_tx_start,
	output logic                      o_tx_busy,
	output logic                      o_tx_restart,
	output logic                      o_tx_load,
	output logic                      o_tx_shift,
	output uart_state_pkg::tx_state_e o_tx_state,
	input  logic                      i_tx_tick,
	input  logic                      i_start_edge,
	input  logic                      i_rx_line,
	output logic                      o_rx_restart,
	output uart_state_pkg::rx_state_e o_rx_state,
	output logic                      o_rx_sample,
	input  logic                      i_rx_tick
);
	import uart_frame_pkg::*;
	import uart_state_pkg::*;

	localparam int CNT_W = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_WIDTH - 1);

	tx_state_e        tx_state;
	tx_state_e        tx_next;
	logic [CNT_W-1:0] tx_count;
	rx_state_e        rx_state;
	rx_state_e        rx_next;
	logic [CNT_W-1:0] rx_count;
	logic             tx_accept;

	assign tx_accept = i_tx_start && tx_state == TX_IDLE;	// starts while busy are dropped

	always_comb begin
		tx_next = tx_state;
		case (tx_state)
			TX_IDLE:  if (i_tx_start) tx_next = TX_START;
			TX_START: if (i_tx_tick) tx_next = TX_DATA;
			TX_DATA: begin
				if (i_tx_tick && tx_count == LAST_BIT) begin
					if (PARITY_MODE == PARITY_NONE) begin
						tx_next = TX_STOP;
					end else begin
						tx_next = TX_PARITY;
					end
				end
			end
			TX_PARITY: if (i_tx_tick) tx_next = TX_STOP;
			TX_STOP:   if (i_tx_tick) tx_next = TX_IDLE;
			default:   tx_next = TX_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_state <= TX_IDLE;
			tx_count <= '0;
		end else begin
			tx_state <= tx_next;
			if (tx_state != TX_DATA) begin
				tx_count <= '0;
			end else if (i_tx_tick) begin
				tx_count <= tx_count + 1'b1;
			end
		end
	end

	assign o_tx_busy    = tx_state != TX_IDLE;
	assign o_tx_restart = tx_accept;
	assign o_tx_load    = tx_accept;
	assign o_tx_shift   = i_tx_tick && tx_state == TX_DATA;
	assign o_tx_state   = tx_next;	// shifter registers the line for the coming state

	always_comb begin
		rx_next = rx_state;
		case (rx_state)
			RX_IDLE: if (i_start_edge) rx_next = RX_START;
			RX_START: begin
				if (i_rx_tick) begin
					if (i_rx_line) begin
						rx_next = RX_IDLE;	// start bit not low at mid-bit is dropped
					end else begin
						rx_next = RX_DATA;
					end
				end
			end
			RX_DATA: begin
				if (i_rx_tick && rx_count == LAST_BIT) begin
					if (PARITY_MODE == PARITY_NONE) begin
						rx_next = RX_STOP;
					end else begin
						rx_next = RX_PARITY;
					end
				end
			end
			RX_PARITY: if (i_rx_tick) rx_next = RX_STOP;
			RX_STOP:   if (i_rx_tick) rx_next = RX_IDLE;
			default:   rx_next = RX_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_state <= RX_IDLE;
			rx_count <= '0;
		end else begin
			rx_state <= rx_next;
			if (rx_state != RX_DATA) begin
				rx_count <= '0;
			end else if (i_rx_tick) begin
				rx_count <= rx_count + 1'b1;
			end
		end
	end

	assign o_rx_restart = i_start_edge && rx_state == RX_IDLE;
	assign o_rx_state   = rx_state;
	assign o_rx_sample  = i_rx_tick && rx_state != RX_IDLE;

endmodule

//--- logic/uart_state_pkg.sv
package uart_state_pkg;

	// transmit sequencer states that also select the tx line value
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} tx_state_e;

	// receive sequencer states that tell the deserializer what a sample means
	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_e;

endpackage

//--- logic/uart_top.sv
module uart_top #(
	parameter int DATA_WIDTH     = uart_frame_pkg::DEFAULT_DATA_WIDTH,
	parameter int CLOCKS_PER_BIT = uart_frame_pkg::DEFAULT_CLOCKS_PER_BIT,
	parameter uart_frame_pkg::parity_mode_e PARITY_MODE = uart_frame_pkg::PARITY_EVEN
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_tx_start,
	input  logic [DATA_WIDTH-1:0] i_tx_data,
	output logic                  o_tx_busy,
	output logic                  o_serial,
	input  logic                  i_serial,
	output logic [DATA_WIDTH-1:0] o_rx_data,
	output logic                  o_rx_valid,
	output logic                  o_rx_error
);
	import uart_frame_pkg::*;
	import uart_state_pkg::*;

	logic      tx_restart;
	logic      tx_load;
	logic      tx_shift;
	logic      tx_tick;
	tx_state_e tx_state;
	logic      start_edge;
	logic      rx_line;
	logic      rx_restart;
	rx_state_e rx_state;
	logic      rx_sample;
	logic      rx_tick;

	uart_sequencer #(
		.DATA_WIDTH  (DATA_WIDTH),
		.PARITY_MODE (PARITY_MODE)
	) sequencer (
		.clk          (clk),
		.reset        (reset),
		.i_tx_start   (i_tx_start),
		.o_tx_busy    (o_tx_busy),
		.o_tx_restart (tx_restart),
		.o_tx_load    (tx_load),
		.o_tx_shift   (tx_shift),
		.o_tx_state   (tx_state),
		.i_tx_tick    (tx_tick),
		.i_start_edge (start_edge),
		.i_rx_line    (rx_line),
		.o_rx_restart (rx_restart),
		.o_rx_state   (rx_state),
		.o_rx_sample  (rx_sample),
		.i_rx_tick    (rx_tick)
	);

	bit_timer #(
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT),
		.PHASE          (PHASE_BOUNDARY)
	) tx_timer (
		.clk       (clk),
		.reset     (reset),
		.i_restart (tx_restart),
		.i_run     (o_tx_busy),
		.o_tick    (tx_tick)
	);

	// mid-bit ticks for sampling the incoming line
	bit_timer #(
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT),
		.PHASE          (PHASE_MIDDLE)
	) rx_timer (
		.clk       (clk),
		.reset     (reset),
		.i_restart (rx_restart),
		.i_run     (rx_state != RX_IDLE),
		.o_tick    (rx_tick)
	);

	tx_shifter #(
		.DATA_WIDTH  (DATA_WIDTH),
		.PARITY_MODE (PARITY_MODE)
	) tx_path (
		.clk        (clk),
		.reset      (reset),
		.i_load     (tx_load),
		.i_shift    (tx_shift),
		.i_data     (i_tx_data),
		.i_line_sel (tx_state),
		.o_serial   (o_serial)
	);

	rx_deserializer #(
		.DATA_WIDTH  (DATA_WIDTH),
		.PARITY_MODE (PARITY_MODE)
	) rx_path (
		.clk          (clk),
		.reset        (reset),
		.i_serial     (i_serial),
		.i_sample     (rx_sample),
		.i_state      (rx_state),
		.o_start_edge (start_edge),
		.o_line       (rx_line),
		.o_data       (o_rx_data),
		.o_valid      (o_rx_valid),
		.o_error      (o_rx_error)
	);

endmodule
